//--- verilog/arb_pkg.sv
/*
 * arb_pkg: arbitration mode and APB register offset enums,
 * APB bus width constants
 */
`default_nettype none

package arb_pkg;

  localparam int APB_ADDR_WIDTH = 8;
  localparam int APB_DATA_WIDTH = 32;

  // fixed ranks by priority only, round robin adds the rotating tie-break
  typedef enum logic {
    ARB_FIXED       = 1'b0,
    ARB_ROUND_ROBIN = 1'b1
  } arb_type_e;

  // byte offsets of the configuration registers
  typedef enum logic [7:0] {
    REG_CTRL     = 8'h00,  // [0] mode, [1] enable, [2] write 1 to reload credits
    REG_PRIORITY = 8'h04,  // 2 bits per requester, requester 0 at the bottom
    REG_WEIGHT   = 8'h08,  // 3 bits per requester, requester 0 at the bottom
    REG_STATUS   = 8'h0c   // read only, last granted index
  } arb_reg_e;

endpackage

`default_nettype wire

//--- verilog/arb_max_finder.sv
/*
 * arb_max_finder: log-depth pairwise comparison tree returning the
 * one-hot location and index of the largest key, lowest index on ties
 */
`default_nettype none

module arb_max_finder #(
  parameter int ENTRIES   = 4,
  parameter int KEY_WIDTH = 5
)(
  input  var logic [ENTRIES*KEY_WIDTH-1:0] i_keys,
  output logic [ENTRIES-1:0]               o_location,
  output logic [$clog2(ENTRIES)-1:0]       o_index
);
  localparam int IDX_W = $clog2(ENTRIES);
  localparam int NODES = 1 << IDX_W;  // leaves padded up to a power of two

  // heap layout, node n has children 2n and 2n+1, leaves start at NODES
  logic [KEY_WIDTH-1:0] node_key [1:2*NODES-1];
  logic [IDX_W-1:0]     node_idx [1:2*NODES-1];

  for (genvar l = 0; l < NODES; l++) begin : g_leaf
    if (l < ENTRIES) begin : g_real
      assign node_key[NODES+l] = i_keys[l*KEY_WIDTH +: KEY_WIDTH];
    end else begin : g_pad
      assign node_key[NODES+l] = '0;  // zero key never beats a lower real entry
    end
    assign node_idx[NODES+l] = IDX_W'(l);
  end

  for (genvar n = 1; n < NODES; n++) begin : g_node
    logic take_right;

    // strict compare keeps the left child, which always holds the lower indices
    assign take_right  = node_key[2*n+1] > node_key[2*n];
    assign node_key[n] = take_right ? node_key[2*n+1] : node_key[2*n];
    assign node_idx[n] = take_right ? node_idx[2*n+1] : node_idx[2*n];
  end

  assign o_index = node_idx[1];

  for (genvar i = 0; i < ENTRIES; i++) begin : g_loc
    assign o_location[i] = (o_index == IDX_W'(i));
  end

endmodule

`default_nettype wire

//--- verilog/arb_apb_regs.sv
/*
 * arb_apb_regs: APB slave holding mode, enable, priorities and reload weights,
 * with a read-only status register and a one-cycle credit reload pulse
 */
`default_nettype none

module arb_apb_regs #(
  parameter int NUM_REQ        = 4,
  parameter int PRIORITY_WIDTH = 2,
  parameter int WEIGHT_WIDTH   = 3
)(
  input  var logic                                    i_clk,
  input  var logic                                    i_rst_n,
  input  var logic                                    i_psel,
  input  var logic                                    i_penable,
  input  var logic                                    i_pwrite,
  input  var logic [arb_pkg::APB_ADDR_WIDTH-1:0]      i_paddr,
  input  var logic [arb_pkg::APB_DATA_WIDTH-1:0]      i_pwdata,
  input  var logic [$clog2(NUM_REQ)-1:0]              i_last_grant,
  output logic [arb_pkg::APB_DATA_WIDTH-1:0]          o_prdata,
  output arb_pkg::arb_type_e                          o_cfg_type,
  output logic                                        o_cfg_enable,
  output logic [NUM_REQ-1:0][PRIORITY_WIDTH-1:0]      o_cfg_priority,
  output logic [NUM_REQ-1:0][WEIGHT_WIDTH-1:0]        o_cfg_weight,
  output logic                                        o_cfg_reload
);
  import arb_pkg::*;

  localparam int IDX_W    = $clog2(NUM_REQ);
  localparam int PRI_BITS = NUM_REQ * PRIORITY_WIDTH;
  localparam int WGT_BITS = NUM_REQ * WEIGHT_WIDTH;

  arb_reg_e reg_addr;
  logic     wr_en;

  assign reg_addr = arb_reg_e'(i_paddr);
  assign wr_en    = i_psel && i_penable && i_pwrite;  // access phase, no wait states

  // reload bit is never stored, it fires in the access cycle of the write
  assign o_cfg_reload = wr_en && (reg_addr == REG_CTRL) && i_pwdata[2];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cfg_type     <= ARB_FIXED;
      o_cfg_enable   <= 1'b0;
      o_cfg_priority <= '0;
      o_cfg_weight   <= {NUM_REQ{WEIGHT_WIDTH'(1)}};
    end else if (wr_en) begin
      case (reg_addr)
        REG_CTRL: begin
          o_cfg_type   <= arb_type_e'(i_pwdata[0]);
          o_cfg_enable <= i_pwdata[1];
        end
        REG_PRIORITY: begin
          o_cfg_priority <= i_pwdata[PRI_BITS-1:0];
        end
        REG_WEIGHT: begin
          o_cfg_weight <= i_pwdata[WGT_BITS-1:0];
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    o_prdata = '0;
    case (reg_addr)
      REG_CTRL: begin
        o_prdata[0] = o_cfg_type;
        o_prdata[1] = o_cfg_enable;  // reload bit always reads back 0
      end
      REG_PRIORITY: begin
        o_prdata[PRI_BITS-1:0] = o_cfg_priority;
      end
      REG_WEIGHT: begin
        o_prdata[WGT_BITS-1:0] = o_cfg_weight;
      end
      REG_STATUS: begin
        o_prdata[IDX_W-1:0] = i_last_grant;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/arb_round_robin_arbiter.sv
/*
 * arb_round_robin_arbiter: key builder, last-grant pointer, weight credits
 * and zero-credit grant counter around the max finder, one-hot grant out
 */
`default_nettype none

module arb_round_robin_arbiter #(
  parameter int NUM_REQ        = 4,
  parameter int PRIORITY_WIDTH = 2,
  parameter int WEIGHT_WIDTH   = 3
)(
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_enable,
  input  var logic                                i_cfg_enable,
  input  var arb_pkg::arb_type_e                  i_cfg_type,
  input  var logic [NUM_REQ-1:0][PRIORITY_WIDTH-1:0] i_cfg_priority,
  input  var logic [NUM_REQ-1:0][WEIGHT_WIDTH-1:0]   i_cfg_weight,
  input  var logic                                i_cfg_reload,
  input  var logic [NUM_REQ-1:0]                  i_request,
  output logic [NUM_REQ-1:0]                      o_grant,
  output logic [$clog2(NUM_REQ)-1:0]              o_grant_index
);
  import arb_pkg::*;

  localparam int IDX_W     = $clog2(NUM_REQ);
  localparam int KEY_WIDTH = 1 + 1 + PRIORITY_WIDTH + 1;
  localparam logic [IDX_W-1:0] LAST_COUNT = IDX_W'(NUM_REQ - 2);

  logic                                  use_rr;
  logic [NUM_REQ-1:0]                    request;
  logic [NUM_REQ*KEY_WIDTH-1:0]          keys;
  logic [NUM_REQ-1:0]                    win_location;
  logic [IDX_W-1:0]                      win_index;
  logic                                  any_grant;
  logic [IDX_W-1:0]                      pointer;
  logic [IDX_W-1:0]                      last_grant;
  logic [NUM_REQ-1:0][WEIGHT_WIDTH-1:0]  credit;
  logic [NUM_REQ-1:0]                    credit_zero;
  logic [NUM_REQ-1:0]                    credit_one;
  logic                                  all_spent;
  logic                                  zero_grant;
  logic [IDX_W-1:0]                      zero_count;
  logic                                  reload;

  assign use_rr  = (i_cfg_type == ARB_ROUND_ROBIN);
  assign request = i_request & {NUM_REQ{i_enable && i_cfg_enable}};  // slot free and enabled

  // key from msb to lsb: request, credit left, priority, above pointer
  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      keys[i*KEY_WIDTH +: KEY_WIDTH] = {request[i],
                                        credit[i] != '0,
                                        i_cfg_priority[i],
                                        use_rr && (IDX_W'(i) > pointer)};
    end
  end

  arb_max_finder #(
    .ENTRIES   (NUM_REQ),
    .KEY_WIDTH (KEY_WIDTH)
  ) u_max_finder (
    .i_keys     (keys),
    .o_location (win_location),
    .o_index    (win_index)
  );

  assign any_grant     = (request != '0);
  assign o_grant       = any_grant ? win_location : '0;
  assign o_grant_index = any_grant ? win_index : last_grant;  // idle cycles show the last winner

  always_comb begin
    for (int i = 0; i < NUM_REQ; i++) begin
      credit_zero[i] = (credit[i] == '0);
      credit_one[i]  = (credit[i] == WEIGHT_WIDTH'(1));
    end
  end

  assign all_spent  = any_grant && ((credit_zero | (o_grant & credit_one)) == '1);
  assign zero_grant = (o_grant & credit_zero) != '0;
  assign reload     = i_cfg_reload || !use_rr || all_spent
                   || (zero_grant && (zero_count == LAST_COUNT));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pointer <= '0;
    end else if (i_cfg_reload || !use_rr) begin
      pointer <= '0;
    end else if (any_grant) begin
      pointer <= win_index;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      last_grant <= '0;
    end else if (any_grant) begin
      last_grant <= win_index;
    end
  end

  // counts consecutive grants to requesters already out of credit
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      zero_count <= '0;
    end else if (reload) begin
      zero_count <= '0;
    end else if (any_grant) begin
      zero_count <= zero_grant ? zero_count + IDX_W'(1) : '0;
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      credit <= {NUM_REQ{WEIGHT_WIDTH'(1)}};
    end else if (reload) begin
      credit <= i_cfg_weight;
    end else begin
      for (int i = 0; i < NUM_REQ; i++) begin
        if (o_grant[i] && !credit_zero[i]) begin
          credit[i] <= credit[i] - WEIGHT_WIDTH'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/arb_grant_mux.sv
/*
 * arb_grant_mux: returns ready to the granted requester and loads its
 * word into the output register drained by the valid/ready pair
 */
`default_nettype none

module arb_grant_mux #(
  parameter int NUM_REQ    = 4,
  parameter int DATA_WIDTH = 16
)(
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic [NUM_REQ-1:0]                  i_grant,
  input  var logic [$clog2(NUM_REQ)-1:0]          i_grant_index,
  input  var logic [NUM_REQ-1:0][DATA_WIDTH-1:0]  i_req_data,
  input  var logic                                i_out_ready,
  output logic                                    o_slot_free,
  output logic [NUM_REQ-1:0]                      o_req_ready,
  output logic                                    o_out_valid,
  output logic [DATA_WIDTH-1:0]                   o_out_data
);
  logic accept;

  // empty, or the held word leaves at this edge
  assign o_slot_free = !o_out_valid || i_out_ready;

  // the arbiter only grants valid requesters while the slot is free
  assign o_req_ready = i_grant;
  assign accept      = (i_grant != '0);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_out_valid <= 1'b0;
    end else if (accept) begin
      o_out_valid <= 1'b1;
    end else if (i_out_ready) begin
      o_out_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_out_data <= i_req_data[i_grant_index];
    end
  end

endmodule

`default_nettype wire

//--- verilog/arb_top.sv
/*
 * arb_top: APB register block, round-robin arbiter and output stage
 */
`default_nettype none

module arb_top #(
  parameter int NUM_REQ        = 4,
  parameter int DATA_WIDTH     = 16,
  parameter int PRIORITY_WIDTH = 2,
  parameter int WEIGHT_WIDTH   = 3
)(
  input  var logic                                i_clk,
  input  var logic                                i_rst_n,
  input  var logic                                i_psel,
  input  var logic                                i_penable,
  input  var logic                                i_pwrite,
  input  var logic [arb_pkg::APB_ADDR_WIDTH-1:0]  i_paddr,
  input  var logic [arb_pkg::APB_DATA_WIDTH-1:0]  i_pwdata,
  output logic [arb_pkg::APB_DATA_WIDTH-1:0]      o_prdata,
  input  var logic [NUM_REQ-1:0]                  i_req_valid,
  input  var logic [NUM_REQ-1:0][DATA_WIDTH-1:0]  i_req_data,
  output logic [NUM_REQ-1:0]                      o_req_ready,
  input  var logic                                i_out_ready,
  output logic                                    o_out_valid,
  output logic [DATA_WIDTH-1:0]                   o_out_data
);
  import arb_pkg::*;

  arb_type_e                             cfg_type;
  logic                                  cfg_enable;
  logic [NUM_REQ-1:0][PRIORITY_WIDTH-1:0] cfg_priority;
  logic [NUM_REQ-1:0][WEIGHT_WIDTH-1:0]  cfg_weight;
  logic                                  cfg_reload;
  logic [NUM_REQ-1:0]                    grant;
  logic [$clog2(NUM_REQ)-1:0]            grant_index;
  logic                                  slot_free;

  arb_apb_regs #(
    .NUM_REQ        (NUM_REQ),
    .PRIORITY_WIDTH (PRIORITY_WIDTH),
    .WEIGHT_WIDTH   (WEIGHT_WIDTH)
  ) u_regs (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_psel         (i_psel),
    .i_penable      (i_penable),
    .i_pwrite       (i_pwrite),
    .i_paddr        (i_paddr),
    .i_pwdata       (i_pwdata),
    .i_last_grant   (grant_index),
    .o_prdata       (o_prdata),
    .o_cfg_type     (cfg_type),
    .o_cfg_enable   (cfg_enable),
    .o_cfg_priority (cfg_priority),
    .o_cfg_weight   (cfg_weight),
    .o_cfg_reload   (cfg_reload)
  );

  arb_round_robin_arbiter #(
    .NUM_REQ        (NUM_REQ),
    .PRIORITY_WIDTH (PRIORITY_WIDTH),
    .WEIGHT_WIDTH   (WEIGHT_WIDTH)
  ) u_arbiter (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_enable       (slot_free),
    .i_cfg_enable   (cfg_enable),
    .i_cfg_type     (cfg_type),
    .i_cfg_priority (cfg_priority),
    .i_cfg_weight   (cfg_weight),
    .i_cfg_reload   (cfg_reload),
    .i_request      (i_req_valid),
    .o_grant        (grant),
    .o_grant_index  (grant_index)
  );

  arb_grant_mux #(
    .NUM_REQ    (NUM_REQ),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_grant_mux (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_grant       (grant),
    .i_grant_index (grant_index),
    .i_req_data    (i_req_data),
    .i_out_ready   (i_out_ready),
    .o_slot_free   (slot_free),
    .o_req_ready   (o_req_ready),
    .o_out_valid   (o_out_valid),
    .o_out_data    (o_out_data)
  );

endmodule

`default_nettype wire

//--- testbench/arb_clk_gen.sv
/*
 * arb_clk_gen: 4 ns clock and active-low reset for the testbench
 */
`default_nettype none

module arb_clk_gen #(
  parameter int RESET_CYCLES = 16
)(
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #2 o_clk = ~o_clk;
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    #1 o_rst_n = 1'b1;  // release away from the edge
  end

endmodule

`default_nettype wire

//--- testbench/arb_checker.sv
/*
 * arb_checker: concurrent assertions on the requester ready vector
 * and the output register handshake, bound into the output stage
 */
`default_nettype none

module arb_checker #(
  parameter int NUM_REQ    = 4,
  parameter int DATA_WIDTH = 16
)(
  input var logic                  i_clk,
  input var logic                  i_rst_n,
  input var logic [NUM_REQ-1:0]    i_req_ready,
  input var logic                  i_slot_free,
  input var logic                  i_out_valid,
  input var logic                  i_out_ready,
  input var logic [DATA_WIDTH-1:0] i_out_data
);
  timeunit 1ns;
  timeprecision 100ps;

  int assert_errors = 0;

  a_ready_onehot : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(i_req_ready))
    else begin
      $error("more than one requester sees ready in the same cycle");
      assert_errors++;
    end

  // a requester is only served while the output register can take its word
  a_ready_needs_slot : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (|i_req_ready) |-> i_slot_free)
    else begin
      $error("ready given while the output register is full and stalled");
      assert_errors++;
    end

  a_out_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
    else begin
      $error("output word changed or dropped while stalled");
      assert_errors++;
    end

endmodule

`default_nettype wire

//--- testbench/arb_tb.sv
/*
 * arb_tb: stimulus file runner driving APB and four requesters,
 * output order scoreboard, compare tasks and watchdog
 */
`default_nettype none

module arb_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import arb_pkg::*;

  localparam int    NUM_REQ        = 4;
  localparam int    DATA_WIDTH     = 16;
  localparam int    PRIORITY_WIDTH = 2;
  localparam int    WEIGHT_WIDTH   = 3;
  localparam string STIM_FILE      = "testbench/arb_stimulus.txt";

  logic                                 clk;
  logic                                 rst_n;
  logic                                 psel;
  logic                                 penable;
  logic                                 pwrite;
  logic [APB_ADDR_WIDTH-1:0]            paddr;
  logic [APB_DATA_WIDTH-1:0]            pwdata;
  logic [APB_DATA_WIDTH-1:0]            prdata;
  logic [NUM_REQ-1:0]                   req_valid;
  logic [NUM_REQ-1:0][DATA_WIDTH-1:0]   req_data;
  logic [NUM_REQ-1:0]                   req_ready;
  logic                                 out_ready;
  logic                                 out_valid;
  logic [DATA_WIDTH-1:0]                out_data;

  string                 lines [$];
  int                    num_lines = 0;
  int                    errors = 0;
  int                    seq [NUM_REQ];
  logic [NUM_REQ-1:0]    pending;
  logic [APB_DATA_WIDTH-1:0] access_prdata;
  logic [DATA_WIDTH-1:0] expect_q [$];  // words in the order they must leave the output

  arb_clk_gen u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  arb_top #(
    .NUM_REQ        (NUM_REQ),
    .DATA_WIDTH     (DATA_WIDTH),
    .PRIORITY_WIDTH (PRIORITY_WIDTH),
    .WEIGHT_WIDTH   (WEIGHT_WIDTH)
  ) dut0 (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_psel      (psel),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata),
    .i_req_valid (req_valid),
    .i_req_data  (req_data),
    .o_req_ready (req_ready),
    .i_out_ready (out_ready),
    .o_out_valid (out_valid),
    .o_out_data  (out_data)
  );

  bind arb_grant_mux arb_checker #(
    .NUM_REQ    (NUM_REQ),
    .DATA_WIDTH (DATA_WIDTH)
  ) u_checker (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req_ready (o_req_ready),
    .i_slot_free (o_slot_free),
    .i_out_valid (o_out_valid),
    .i_out_ready (i_out_ready),
    .i_out_data  (o_out_data)
  );

  task automatic check_prdata(input logic [APB_DATA_WIDTH-1:0] actual, expected);
    if (actual !== expected) begin
      $display("CHECK FAILED o_prdata: got %h, expected %h", actual, expected);
      errors++;
    end
  endtask

  task automatic check_grant(input logic [NUM_REQ-1:0] actual, expected);
    if (actual !== expected) begin
      $display("CHECK FAILED o_req_ready: got %h, expected %h", actual, expected);
      errors++;
    end
  endtask

  task automatic check_out_data(input logic [DATA_WIDTH-1:0] actual, expected);
    if (actual !== expected) begin
      $display("CHECK FAILED o_out_data: got %h, expected %h", actual, expected);
      errors++;
    end
  endtask

  // requester index in the upper byte, its own word count in the lower byte
  function automatic logic [DATA_WIDTH-1:0] word_for(input int k);
    return DATA_WIDTH'((k << 8) | (seq[k] & 8'hff));
  endfunction

  task automatic drive_requests();
    req_valid = pending;
    for (int k = 0; k < NUM_REQ; k++) begin
      req_data[k] = word_for(k);
    end
  endtask

  // inputs are already driven so sample at the falling edge and step to the next one
  task automatic run_cycle(input logic [NUM_REQ-1:0] exp_ready);
    logic [NUM_REQ-1:0] taken;
    @(negedge clk);
    taken         = req_ready;
    access_prdata = prdata;
    check_grant(taken, exp_ready);
    for (int k = 0; k < NUM_REQ; k++) begin
      if (exp_ready[k]) begin
        expect_q.push_back(word_for(k));
      end
    end
    @(posedge clk);
    #1;
    for (int k = 0; k < NUM_REQ; k++) begin
      if (taken[k]) begin
        seq[k] = seq[k] + 1;
      end
    end
    pending = pending & ~taken;
    drive_requests();
  endtask

  task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    run_cycle('0);
    penable = 1'b1;
    run_cycle('0);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic hold_output(input int cycles);
    logic [DATA_WIDTH-1:0] held;
    out_ready = 1'b0;
    if (expect_q.size() == 0) begin
      $display("back-pressure hold started with no word waiting in the output register");
      errors++;
      held = '0;
    end else begin
      held = expect_q[0];  // oldest accepted word not yet delivered
    end
    for (int i = 0; i < cycles; i++) begin
      run_cycle('0);
      if (out_valid !== 1'b1) begin
        $display("output register dropped its word during back-pressure");
        errors++;
      end
      check_out_data(out_data, held);
    end
    out_ready = 1'b1;
  endtask

  task automatic run_line(input string line);
    string              kind;
    string              win;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [NUM_REQ-1:0] expected;
    int                 n;
    n = $sscanf(line, "%s", kind);
    if (n == 1 && kind != "#") begin
      case (kind)
        "W": begin
          n = $sscanf(line, "%s %h %h", kind, a, b);
          apb_access(1'b1, a[APB_ADDR_WIDTH-1:0], b);
        end
        "R": begin
          n = $sscanf(line, "%s %h %h", kind, a, b);
          apb_access(1'b0, a[APB_ADDR_WIDTH-1:0], '0);
          check_prdata(access_prdata, b);
        end
        "Q": begin
          n = $sscanf(line, "%s %h %s", kind, a, win);
          expected = (win == "none") ? '0 : (NUM_REQ'(1) << win.atoi());
          pending  = pending | a[NUM_REQ-1:0];
          drive_requests();
          run_cycle(expected);
        end
        "H": begin
          n = $sscanf(line, "%s %d", kind, a);
          hold_output(int'(a));
        end
        default: begin
          $display("unknown line in the stimulus file: %s", line);
          errors++;
        end
      endcase
    end
  endtask

  // every word that leaves the output register is matched against the expected order
  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (expect_q.size() == 0) begin
        $display("output register delivered word %h that was never accepted", out_data);
        errors++;
      end else begin
        check_out_data(out_data, expect_q.pop_front());
      end
    end
  end

  initial begin
    wait (num_lines > 0);
    repeat (num_lines * 20) @(posedge clk);
    $display("timeout: stimulus did not complete within %0d cycles", num_lines * 20);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int    fd;
    string line;
    int    assert_fails;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    req_valid = '0;
    req_data  = '0;
    out_ready = 1'b1;
    pending   = '0;
    for (int k = 0; k < NUM_REQ; k++) begin
      seq[k] = 0;
    end
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("could not open the stimulus file %s", STIM_FILE);
      errors++;
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
      num_lines = lines.size();
      @(posedge rst_n);
      @(posedge clk);
      #1;
      foreach (lines[i]) begin
        run_line(lines[i]);
      end
      repeat (2) run_cycle('0);  // let the last word drain
    end
    if (expect_q.size() != 0) begin
      $display("%0d accepted words never reached the output", expect_q.size());
      errors++;
    end
    assert_fails = dut0.u_grant_mux.u_checker.assert_errors;
    $display("run complete: %0d check errors, %0d assertion errors", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/arb_stimulus.txt
# W addr data | R addr expected_prdata | Q new_valid_mask winner_or_none | H stall_cycles
# values in hex, a requester in the mask stays valid until it is accepted
R 00 00000000
R 08 00000249
R 0c 00000000
Q f none
W 00 00000002
Q 0 0
Q 0 1
Q 0 2
Q 0 3
W 04 00000070
Q f 2
Q 0 3
Q 0 0
Q 0 1
W 04 00000000
W 00 00000003
Q f 1
Q f 2
Q f 3
Q f 0
Q 0 1
Q 0 2
Q 0 3
R 0c 00000003
W 08 0000064a
W 00 00000007
Q f 1
Q f 2
Q f 3
Q f 0
Q f 3
Q f 0
Q f 3
Q f 0
H 3
Q 0 1
Q 0 2
Q 0 3
R 08 0000064a
R 00 00000003

//--- filelist.f
verilog/arb_pkg.sv
verilog/arb_max_finder.sv
verilog/arb_apb_regs.sv
verilog/arb_round_robin_arbiter.sv
verilog/arb_grant_mux.sv
verilog/arb_top.sv
testbench/arb_clk_gen.sv
testbench/arb_checker.sv
testbench/arb_tb.sv

//--- Bender.yml
package:
  name: arb

sources:
  - files:
      - verilog/arb_pkg.sv
      - verilog/arb_max_finder.sv
      - verilog/arb_apb_regs.sv
      - verilog/arb_round_robin_arbiter.sv
      - verilog/arb_grant_mux.sv
      - verilog/arb_top.sv
  - target: test
    files:
      - testbench/arb_clk_gen.sv
      - testbench/arb_checker.sv
      - testbench/arb_tb.sv
